//--- Makefile
TOOL       ?= verilator
TOP        ?= tb_mem_emu
FILE_LIST  ?= verilog.f
FLAGS      ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing -Wall
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
FAIL_MSG   := >>> FAIL

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILE_LIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q -F '$(FAIL_MSG)' $(LOG); then \
		echo "Simulation failed"; exit 1; \
	fi
	@if ! grep -q -F '>>> PASS' $(LOG); then \
		echo "Simulation ended without a result"; exit 1; \
	fi

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILE_LIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- hdl/mem_ans_if.sv
interface mem_ans_if;

    // Handshake
    logic valid;
    logic ready;

    // Payload
    mem_emu_pkg::mem_ans_t ans;

    // Producer side drives the record
    modport prod (
        output valid,
        output ans,
        input  ready
    );

    // Consumer side accepts it
    modport cons (
        input  valid,
        input  ans,
        output ready
    );

endinterface

//--- hdl/mem_emu_pkg.sv
package mem_emu_pkg;

    // Sizes
    // ----------------------------------------
    localparam int unsigned XLEN            = 64;
    localparam int unsigned ADDR_W          = 32;
    localparam int unsigned TAG_W           = 4;
    localparam int unsigned MEM_DEPTH       = 256;
    localparam int unsigned MEM_PIPE_STAGES = 2;

    // Derived array geometry
    localparam int unsigned MEM_IDX_W = $clog2(MEM_DEPTH);
    localparam int unsigned DW_OFF_W  = $clog2(XLEN / 8);
    localparam logic [ADDR_W-1:0] MEM_BYTES = ADDR_W'(MEM_DEPTH * (XLEN / 8));

    // Encodings
    // ----------------------------------------
    typedef enum logic [1:0] {
        MEM_ACC_INSTR = 2'd0,
        MEM_ACC_LD    = 2'd1,
        MEM_ACC_ST    = 2'd2
    } mem_acc_t;

    typedef enum logic [2:0] {
        LS_BYTE       = 3'd0,
        LS_BYTE_U     = 3'd1,
        LS_HALFWORD   = 3'd2,
        LS_HALFWORD_U = 3'd3,
        LS_WORD       = 3'd4,
        LS_WORD_U     = 3'd5,
        LS_DOUBLEWORD = 3'd6
    } ls_type_t;

    // RISC-V mcause values
    typedef enum logic [4:0] {
        E_I_ADDR_MISALIGNED  = 5'd0,
        E_I_ACCESS_FAULT     = 5'd1,
        E_LD_ADDR_MISALIGNED = 5'd4,
        E_LD_ACCESS_FAULT    = 5'd5,
        E_ST_ADDR_MISALIGNED = 5'd6,
        E_ST_ACCESS_FAULT    = 5'd7,
        E_UNKNOWN            = 5'd31
    } except_code_t;

    // Request and answer records
    // ----------------------------------------
    typedef struct packed {
        logic [TAG_W-1:0]  tag;
        mem_acc_t          acc_type;
        ls_type_t          ls_type;
        logic [ADDR_W-1:0] addr;
        logic [XLEN-1:0]   value;
    } mem_req_t;

    typedef struct packed {
        logic [TAG_W-1:0]  tag;
        mem_acc_t          acc_type;
        logic [ADDR_W-1:0] addr;
        logic [XLEN-1:0]   value;
        logic              except_raised;
        except_code_t      except_code;
    } mem_ans_t;

    // One doubleword seen as bytes, halfwords, words or whole
    typedef union packed {
        logic [7:0][7:0]  b;
        logic [3:0][15:0] h;
        logic [1:0][31:0] w;
        logic [63:0]      d;
    } mem_lane_u;

endpackage

//--- hdl/mem_emu_top.sv
module mem_emu_top (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  flush_i,

    // Instruction port
    input  logic                  ins_valid_i,
    output logic                  ins_ready_o,
    input  mem_emu_pkg::mem_req_t ins_req_i,
    output logic                  ins_valid_o,
    input  logic                  ins_ready_i,
    output mem_emu_pkg::mem_ans_t ins_ans_o,

    // Data port
    input  logic                  data_valid_i,
    output logic                  data_ready_o,
    input  mem_emu_pkg::mem_req_t data_req_i,
    output logic                  data_valid_o,
    input  logic                  data_ready_i,
    output mem_emu_pkg::mem_ans_t data_ans_o
);

    import mem_emu_pkg::*;

    logic            ins_exc, data_exc;
    except_code_t    ins_code, data_code;
    logic [XLEN-1:0] ins_rdata, data_rdata;
    logic            data_we;
    mem_ans_t        ins_ans, data_ans;

    mem_ans_if ins_ans_if ();
    mem_ans_if data_ans_if ();

    // Request checks and storage
    // ----------------------------------------
    mem_req_check u_ins_check (
        .req_i           (ins_req_i),
        .except_raised_o (ins_exc),
        .except_code_o   (ins_code)
    );

    mem_req_check u_data_check (
        .req_i           (data_req_i),
        .except_raised_o (data_exc),
        .except_code_o   (data_code)
    );

    // Faulting stores leave the array untouched
    assign data_we = data_valid_i & data_ready_o & ~data_exc &
                     (data_req_i.acc_type == MEM_ACC_ST);

    mem_storage u_storage (
        .clk_i        (clk_i),
        .ins_addr_i   (ins_req_i.addr),
        .ins_rdata_o  (ins_rdata),
        .data_req_i   (data_req_i),
        .data_we_i    (data_we),
        .data_rdata_o (data_rdata)
    );

    // Answer records
    // ----------------------------------------
    always_comb begin : p_ins_ans
        ins_ans.tag           = ins_req_i.tag;
        ins_ans.acc_type      = ins_req_i.acc_type;
        ins_ans.addr          = ins_req_i.addr;
        ins_ans.value         = ins_exc ? '0 : ins_rdata;
        ins_ans.except_raised = ins_exc;
        ins_ans.except_code   = ins_code;
    end

    always_comb begin : p_data_ans
        data_ans.tag           = data_req_i.tag;
        data_ans.acc_type      = data_req_i.acc_type;
        data_ans.addr          = data_req_i.addr;
        // Stores answer with a zero value
        data_ans.value         = (data_req_i.acc_type == MEM_ACC_LD && !data_exc) ?
                                 data_rdata : '0;
        data_ans.except_raised = data_exc;
        data_ans.except_code   = data_code;
    end

    // Latency pipes and output cells
    // ----------------------------------------
    assign ins_ready_o  = ins_ans_if.ready;
    assign data_ready_o = data_ans_if.ready;

    mem_latency_pipe #(
        .NUM_STAGES (MEM_PIPE_STAGES)
    ) u_ins_pipe (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .flush_i (flush_i),
        .en_i    (ins_ans_if.ready),
        .valid_i (ins_valid_i),
        .ans_i   (ins_ans),
        .out     (ins_ans_if)
    );

    mem_latency_pipe #(
        .NUM_STAGES (MEM_PIPE_STAGES)
    ) u_data_pipe (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .flush_i (flush_i),
        .en_i    (data_ans_if.ready),
        .valid_i (data_valid_i),
        .ans_i   (data_ans),
        .out     (data_ans_if)
    );

    spill_cell_flush u_ins_out_reg (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .flush_i (flush_i),
        .in      (ins_ans_if),
        .valid_o (ins_valid_o),
        .ready_i (ins_ready_i),
        .data_o  (ins_ans_o)
    );

    spill_cell_flush u_data_out_reg (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .flush_i (flush_i),
        .in      (data_ans_if),
        .valid_o (data_valid_o),
        .ready_i (data_ready_i),
        .data_o  (data_ans_o)
    );

    // Instruction port is fetch only
    a_ins_fetch_only: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        ins_valid_i |-> ins_req_i.acc_type == MEM_ACC_INSTR);

endmodule

//--- hdl/mem_latency_pipe.sv
module mem_latency_pipe #(
    parameter int unsigned NUM_STAGES = mem_emu_pkg::MEM_PIPE_STAGES
) (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  flush_i,
    input  logic                  en_i,
    input  logic                  valid_i,
    input  mem_emu_pkg::mem_ans_t ans_i,
    mem_ans_if.prod               out
);

    import mem_emu_pkg::*;

    if (NUM_STAGES == 0) begin : g_bypass
        assign out.valid = valid_i;
        assign out.ans   = ans_i;
    end else begin : g_stages
        logic [NUM_STAGES-1:0] valid_q;
        mem_ans_t              ans_q [NUM_STAGES];

        // Valid chain where bubbles shift along too
        always_ff @(posedge clk_i) begin : p_valid
            if (!rst_n_i) begin
                valid_q <= '0;
            end else if (flush_i) begin
                valid_q <= '0;
            end else if (en_i) begin
                valid_q[0] <= valid_i;
                for (int i = 1; i < NUM_STAGES; i++) begin
                    valid_q[i] <= valid_q[i-1];
                end
            end
        end

        always_ff @(posedge clk_i) begin : p_payload
            if (en_i) begin
                ans_q[0] <= ans_i;
                for (int i = 1; i < NUM_STAGES; i++) begin
                    ans_q[i] <= ans_q[i-1];
                end
            end
        end

        assign out.valid = valid_q[NUM_STAGES-1];
        assign out.ans   = ans_q[NUM_STAGES-1];
    end

endmodule

//--- hdl/mem_req_check.sv
module mem_req_check (
    input  mem_emu_pkg::mem_req_t     req_i,
    output logic                      except_raised_o,
    output mem_emu_pkg::except_code_t except_code_o
);

    import mem_emu_pkg::*;

    logic [DW_OFF_W-1:0] align_mask;
    logic                misaligned;
    logic                out_of_range;

    // Alignment check
    // ----------------------------------------
    always_comb begin : p_align
        align_mask = '0;
        if (req_i.acc_type == MEM_ACC_INSTR) begin
            // Fetches are always word accesses
            align_mask = 3'b011;
        end else begin
            case (req_i.ls_type)
                LS_BYTE, LS_BYTE_U:         align_mask = 3'b000;
                LS_HALFWORD, LS_HALFWORD_U: align_mask = 3'b001;
                LS_WORD, LS_WORD_U:         align_mask = 3'b011;
                default:                    align_mask = 3'b111;
            endcase
        end
    end

    assign misaligned   = |(req_i.addr[DW_OFF_W-1:0] & align_mask);
    assign out_of_range = (req_i.addr >= MEM_BYTES);

    // Exception code
    // ----------------------------------------
    always_comb begin : p_code
        except_raised_o = misaligned | out_of_range;
        except_code_o   = E_UNKNOWN;
        // Misalignment wins over an access fault
        if (misaligned) begin
            case (req_i.acc_type)
                MEM_ACC_INSTR: except_code_o = E_I_ADDR_MISALIGNED;
                MEM_ACC_LD:    except_code_o = E_LD_ADDR_MISALIGNED;
                MEM_ACC_ST:    except_code_o = E_ST_ADDR_MISALIGNED;
                default:       except_code_o = E_UNKNOWN;
            endcase
        end else if (out_of_range) begin
            case (req_i.acc_type)
                MEM_ACC_INSTR: except_code_o = E_I_ACCESS_FAULT;
                MEM_ACC_LD:    except_code_o = E_LD_ACCESS_FAULT;
                MEM_ACC_ST:    except_code_o = E_ST_ACCESS_FAULT;
                default:       except_code_o = E_UNKNOWN;
            endcase
        end
    end

    // Data accesses must carry a known size
    always_comb begin : p_ls_check
        a_ls_defined: assert final (req_i.acc_type == MEM_ACC_INSTR ||
                                    req_i.ls_type != 3'd7);
    end

endmodule

//--- hdl/mem_storage.sv
module mem_storage (
    input  logic                           clk_i,

    // Instruction read port
    input  logic [mem_emu_pkg::ADDR_W-1:0] ins_addr_i,
    output logic [mem_emu_pkg::XLEN-1:0]   ins_rdata_o,

    // Data read/write port
    input  mem_emu_pkg::mem_req_t          data_req_i,
    input  logic                           data_we_i,
    output logic [mem_emu_pkg::XLEN-1:0]   data_rdata_o
);

    import mem_emu_pkg::*;

    // Doubleword array
    logic [XLEN-1:0] mem_q [MEM_DEPTH];

    logic [MEM_IDX_W-1:0] ins_idx;
    logic [MEM_IDX_W-1:0] data_idx;
    logic [DW_OFF_W-1:0]  data_off;
    mem_lane_u            ins_lane;
    mem_lane_u            rd_lane;
    mem_lane_u            wr_lane;

    assign ins_idx  = ins_addr_i[DW_OFF_W +: MEM_IDX_W];
    assign data_idx = data_req_i.addr[DW_OFF_W +: MEM_IDX_W];
    assign data_off = data_req_i.addr[DW_OFF_W-1:0];

    // Instruction fetch
    // ----------------------------------------
    assign ins_lane    = mem_q[ins_idx];
    assign ins_rdata_o = {{(XLEN-32){1'b0}}, ins_lane.w[ins_addr_i[2]]};

    // Data load with extension
    // ----------------------------------------
    assign rd_lane = mem_q[data_idx];

    always_comb begin : p_load
        case (data_req_i.ls_type)
            LS_BYTE: begin
                data_rdata_o = {{(XLEN-8){rd_lane.b[data_off][7]}}, rd_lane.b[data_off]};
            end
            LS_BYTE_U: begin
                data_rdata_o = {{(XLEN-8){1'b0}}, rd_lane.b[data_off]};
            end
            LS_HALFWORD: begin
                data_rdata_o = {{(XLEN-16){rd_lane.h[data_off[2:1]][15]}},
                                rd_lane.h[data_off[2:1]]};
            end
            LS_HALFWORD_U: begin
                data_rdata_o = {{(XLEN-16){1'b0}}, rd_lane.h[data_off[2:1]]};
            end
            LS_WORD: begin
                data_rdata_o = {{(XLEN-32){rd_lane.w[data_off[2]][31]}},
                                rd_lane.w[data_off[2]]};
            end
            LS_WORD_U: begin
                data_rdata_o = {{(XLEN-32){1'b0}}, rd_lane.w[data_off[2]]};
            end
            default: begin
                data_rdata_o = rd_lane.d;
            end
        endcase
    end

    // Store merge
    // ----------------------------------------
    always_comb begin : p_merge
        wr_lane = rd_lane;
        case (data_req_i.ls_type)
            LS_BYTE, LS_BYTE_U: begin
                wr_lane.b[data_off] = data_req_i.value[7:0];
            end
            LS_HALFWORD, LS_HALFWORD_U: begin
                wr_lane.h[data_off[2:1]] = data_req_i.value[15:0];
            end
            LS_WORD, LS_WORD_U: begin
                wr_lane.w[data_off[2]] = data_req_i.value[31:0];
            end
            default: begin
                wr_lane.d = data_req_i.value;
            end
        endcase
    end

    // Write lands on the edge, so a fetch in the same cycle reads old data
    always_ff @(posedge clk_i) begin : p_write
        if (data_we_i) begin
            mem_q[data_idx] <= wr_lane.d;
        end
    end

    // Only stores may reach the write port
    a_we_store: assert property (@(posedge clk_i)
        data_we_i |-> data_req_i.acc_type == MEM_ACC_ST);

endmodule

//--- hdl/spill_cell_flush.sv
module spill_cell_flush (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  flush_i,
    mem_ans_if.cons               in,
    output logic                  valid_o,
    input  logic                  ready_i,
    output mem_emu_pkg::mem_ans_t data_o
);

    import mem_emu_pkg::*;

    logic     main_valid_q;
    logic     spill_valid_q;
    mem_ans_t main_q;
    mem_ans_t spill_q;
    logic     main_load;
    logic     in_hs;

    // Main register is free or being drained this cycle
    assign main_load = ~main_valid_q | ready_i;
    assign in_hs     = in.valid & in.ready;

    // Ready comes straight from a flop
    assign in.ready = ~spill_valid_q;

    // Control
    // ----------------------------------------
    always_ff @(posedge clk_i) begin : p_ctrl
        if (!rst_n_i) begin
            main_valid_q  <= 1'b0;
            spill_valid_q <= 1'b0;
        end else if (flush_i) begin
            main_valid_q  <= 1'b0;
            spill_valid_q <= 1'b0;
        end else if (main_load) begin
            // Spill entry drains first while the input is blocked
            main_valid_q  <= spill_valid_q | in.valid;
            spill_valid_q <= 1'b0;
        end else if (in_hs) begin
            spill_valid_q <= 1'b1;
        end
    end

    // Payload
    // ----------------------------------------
    always_ff @(posedge clk_i) begin : p_data
        if (main_load) begin
            main_q <= spill_valid_q ? spill_q : in.ans;
        end
        if (!main_load && in_hs) begin
            spill_q <= in.ans;
        end
    end

    assign valid_o = main_valid_q;
    assign data_o  = main_q;

    // Held answer must not change before it is taken
    a_out_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i || flush_i)
        valid_o && !ready_i |=> valid_o && $stable(data_o));

endmodule

//--- sim/tb_mem_emu_vectors.svh
// Stimulus table with one request per row and the low bits of the row number as tag
// Row fields are name, port (0 instr, 1 data), held for flush, random data, access,
// size, address and store data
// Held rows come in runs of at most MEM_PIPE_STAGES so the flush catches them in the pipe
task automatic build_table();
    // Store and load round trip
    add_row("st_d",     1, 0, 1, MEM_ACC_ST,    LS_DOUBLEWORD, 32'h0000_0100, 64'h0);
    add_row("ld_d",     1, 0, 0, MEM_ACC_LD,    LS_DOUBLEWORD, 32'h0000_0100, 64'h0);
    add_row("st_w",     1, 0, 0, MEM_ACC_ST,    LS_WORD,       32'h0000_0104, 64'h8765_4321);
    add_row("ld_w",     1, 0, 0, MEM_ACC_LD,    LS_WORD,       32'h0000_0104, 64'h0);
    add_row("ld_wu",    1, 0, 0, MEM_ACC_LD,    LS_WORD_U,     32'h0000_0104, 64'h0);
    add_row("st_h",     1, 0, 0, MEM_ACC_ST,    LS_HALFWORD,   32'h0000_0102, 64'h9abc);
    add_row("ld_h",     1, 0, 0, MEM_ACC_LD,    LS_HALFWORD,   32'h0000_0102, 64'h0);
    add_row("ld_hu",    1, 0, 0, MEM_ACC_LD,    LS_HALFWORD_U, 32'h0000_0102, 64'h0);
    add_row("st_b",     1, 0, 0, MEM_ACC_ST,    LS_BYTE,       32'h0000_0101, 64'hf0);
    add_row("ld_b",     1, 0, 0, MEM_ACC_LD,    LS_BYTE,       32'h0000_0101, 64'h0);
    add_row("ld_bu",    1, 0, 0, MEM_ACC_LD,    LS_BYTE_U,     32'h0000_0101, 64'h0);
    add_row("ld_merge", 1, 0, 0, MEM_ACC_LD,    LS_DOUBLEWORD, 32'h0000_0100, 64'h0);
    // Fetch after store
    add_row("st_code",  1, 0, 0, MEM_ACC_ST,    LS_WORD,       32'h0000_0200,
            64'h1234_5678_cafe_f00d);
    add_row("if_low",   0, 0, 0, MEM_ACC_INSTR, LS_WORD,       32'h0000_0200, 64'h0);
    add_row("st_code2", 1, 0, 1, MEM_ACC_ST,    LS_DOUBLEWORD, 32'h0000_0208, 64'h0);
    add_row("if_high",  0, 0, 0, MEM_ACC_INSTR, LS_WORD,       32'h0000_020c, 64'h0);
    // Exceptions where the last load shows the faulting stores wrote nothing
    add_row("if_mis",   0, 0, 0, MEM_ACC_INSTR, LS_WORD,       32'h0000_0202, 64'h0);
    add_row("ld_mis",   1, 0, 0, MEM_ACC_LD,    LS_HALFWORD,   32'h0000_0101, 64'h0);
    add_row("st_mis",   1, 0, 1, MEM_ACC_ST,    LS_WORD,       32'h0000_0106, 64'h0);
    add_row("if_oor",   0, 0, 0, MEM_ACC_INSTR, LS_WORD,       32'h0000_0800, 64'h0);
    add_row("ld_oor",   1, 0, 0, MEM_ACC_LD,    LS_DOUBLEWORD, 32'h0000_1000, 64'h0);
    add_row("st_oor",   1, 0, 1, MEM_ACC_ST,    LS_BYTE,       32'h0000_0800, 64'h0);
    add_row("st_both",  1, 0, 1, MEM_ACC_ST,    LS_DOUBLEWORD, 32'h0000_0801, 64'h0);
    add_row("ld_keep",  1, 0, 0, MEM_ACC_LD,    LS_DOUBLEWORD, 32'h0000_0100, 64'h0);
    // Flush where the held store must still land
    add_row("if_flush", 0, 1, 0, MEM_ACC_INSTR, LS_WORD,       32'h0000_0200, 64'h0);
    add_row("st_flush", 1, 1, 1, MEM_ACC_ST,    LS_WORD,       32'h0000_0300, 64'h0);
    add_row("ld_flush", 1, 0, 0, MEM_ACC_LD,    LS_WORD_U,     32'h0000_0300, 64'h0);
endtask

//--- sim/tb_mem_emu.sv
module tb_mem_emu;

    import mem_emu_pkg::*;

    localparam int unsigned BYTE_IDX_W = $clog2(MEM_DEPTH * 8);

    logic     clk_i = 1'b0;
    logic     rst_n_i;
    logic     flush_i;
    logic     ins_valid_i;
    logic     ins_ready_o;
    mem_req_t ins_req_i;
    logic     ins_valid_o;
    logic     ins_ready_i;
    mem_ans_t ins_ans_o;
    logic     data_valid_i;
    logic     data_ready_o;
    mem_req_t data_req_i;
    logic     data_valid_o;
    logic     data_ready_i = 1'b1;
    mem_ans_t data_ans_o;

    // Table rows
    string    row_name [$];
    bit       row_port [$];
    bit       row_held [$];
    bit       row_rnd [$];
    mem_req_t row_req [$];
    int       n_rows = 0;

    // Expected answers, indexed by issue number
    mem_ans_t exp_ans [256];
    string    exp_name [256];
    int       exp_cyc [256];
    bit       exp_lat [256];
    int       ins_pend_q [$];
    int       data_pend_q [$];

    logic [7:0] ref_mem [MEM_DEPTH * 8];
    bit         stall_en = 1'b0;
    int         cycle = 0;
    int         n_issued = 0;
    int         n_recv = 0;
    int         n_checks = 0;
    int         n_val_err = 0;
    int         n_other_err = 0;

    mem_emu_top i_mem_emu_top (.*);

    always #10 clk_i = ~clk_i;

    always @(posedge clk_i) cycle <= cycle + 1;

    // Random back-pressure on the data port only
    always @(posedge clk_i) begin : p_stall
        data_ready_i <= stall_en ? (($urandom % 4) != 0) : 1'b1;
    end

    function automatic void add_row(input string name, input bit port, input bit held,
                                    input bit rnd, input mem_acc_t acc, input ls_type_t ls,
                                    input logic [ADDR_W-1:0] addr,
                                    input logic [XLEN-1:0] value);
        mem_req_t req;
        req.tag      = TAG_W'(row_req.size());
        req.acc_type = acc;
        req.ls_type  = ls;
        req.addr     = addr;
        req.value    = value;
        row_name.push_back(name);
        row_port.push_back(port);
        row_held.push_back(held);
        row_rnd.push_back(rnd);
        row_req.push_back(req);
    endfunction

    `include "tb_mem_emu_vectors.svh"

    // Reference model
    // ----------------------------------------
    task automatic model_access(input mem_req_t req, output mem_ans_t ans);
        int unsigned     size;
        int              code;
        logic            sgn;
        logic            mis;
        logic            oor;
        logic [XLEN-1:0] v;
        size = 8;
        if (req.acc_type == MEM_ACC_INSTR) begin
            size = 4;
        end else if (req.ls_type inside {LS_BYTE, LS_BYTE_U}) begin
            size = 1;
        end else if (req.ls_type inside {LS_HALFWORD, LS_HALFWORD_U}) begin
            size = 2;
        end else if (req.ls_type inside {LS_WORD, LS_WORD_U}) begin
            size = 4;
        end
        sgn = (req.acc_type != MEM_ACC_INSTR) &&
              (req.ls_type inside {LS_BYTE, LS_HALFWORD, LS_WORD});
        mis = (req.addr % size) != 0;
        oor = req.addr >= MEM_DEPTH * 8;
        ans.tag           = req.tag;
        ans.acc_type      = req.acc_type;
        ans.addr          = req.addr;
        ans.value         = '0;
        ans.except_raised = mis | oor;
        ans.except_code   = E_UNKNOWN;
        if (mis || oor) begin
            // Access fault code sits one above the misaligned code
            code = (req.acc_type == MEM_ACC_INSTR) ? 0 : (req.acc_type == MEM_ACC_LD) ? 4 : 6;
            ans.except_code = except_code_t'(mis ? code : code + 1);
        end else if (req.acc_type == MEM_ACC_ST) begin
            for (int i = 0; i < size; i++) begin
                ref_mem[BYTE_IDX_W'(req.addr + i)] = req.value[8*i +: 8];
            end
        end else begin
            v = '0;
            for (int i = 0; i < size; i++) begin
                v[8*i +: 8] = ref_mem[BYTE_IDX_W'(req.addr + i)];
            end
            if (sgn) begin
                for (int i = 8 * size; i < XLEN; i++) begin
                    v[i] = v[8*size-1];
                end
            end
            ans.value = v;
        end
    endtask

    // Checks
    // ----------------------------------------
    task automatic check_ans(input string name, input mem_ans_t exp, input mem_ans_t act);
        n_checks++;
        if (act !== exp) begin
            $display("FAILED %s: expected %h actual %h", name, exp, act);
            n_val_err++;
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        n_checks++;
        if (act != exp) begin
            $display("FAILED %s: expected %0d actual %0d", name, exp, act);
            n_val_err++;
        end
    endtask

    task automatic take_answer(input bit port, input mem_ans_t act);
        int id;
        n_recv++;
        if ((port ? data_pend_q.size() : ins_pend_q.size()) == 0) begin
            $display("Answer with tag %0d on port %0d that no request is waiting for",
                     act.tag, port);
            n_other_err++;
        end else begin
            id = port ? data_pend_q.pop_front() : ins_pend_q.pop_front();
            check_ans(exp_name[id], exp_ans[id], act);
            if (exp_lat[id]) begin
                check_count({exp_name[id], " latency"}, MEM_PIPE_STAGES + 1,
                            cycle + 1 - exp_cyc[id]);
            end
        end
    endtask

    // Outputs are sampled on the falling edge
    always @(negedge clk_i) begin : p_monitor
        if (rst_n_i) begin
            if (ins_valid_o && ins_ready_i) begin
                take_answer(1'b0, ins_ans_o);
            end
            if (data_valid_o && data_ready_i) begin
                take_answer(1'b1, data_ans_o);
            end
        end
    end

    // Driver
    // ----------------------------------------
    task automatic issue_row(input int r);
        mem_req_t req;
        mem_ans_t exp;
        req = row_req[r];
        if (row_rnd[r]) begin
            req.value = {$urandom, $urandom};
        end
        @(posedge clk_i);
        ins_valid_i  <= !row_port[r];
        data_valid_i <= row_port[r];
        if (row_port[r]) begin
            data_req_i <= req;
        end else begin
            ins_req_i <= req;
        end
        @(negedge clk_i);
        while (!(row_port[r] ? data_ready_o : ins_ready_o)) begin
            @(negedge clk_i);
        end
        // Accepted on the coming rising edge
        model_access(req, exp);
        if (!row_held[r]) begin
            exp_ans[n_issued]  = exp;
            exp_name[n_issued] = row_name[r];
            exp_cyc[n_issued]  = cycle + 1;
            exp_lat[n_issued]  = !row_port[r] || !stall_en;
            if (row_port[r]) begin
                data_pend_q.push_back(n_issued);
            end else begin
                ins_pend_q.push_back(n_issued);
            end
            n_issued++;
        end
    endtask

    task automatic wait_drain();
        @(posedge clk_i);
        ins_valid_i  <= 1'b0;
        data_valid_i <= 1'b0;
        while (ins_pend_q.size() != 0 || data_pend_q.size() != 0) begin
            @(posedge clk_i);
        end
        // Room for a stray answer to show up
        repeat (MEM_PIPE_STAGES + 4) @(posedge clk_i);
    endtask

    task automatic raise_flush();
        @(posedge clk_i);
        ins_valid_i  <= 1'b0;
        data_valid_i <= 1'b0;
        flush_i      <= 1'b1;
        @(posedge clk_i);
        flush_i <= 1'b0;
        @(negedge clk_i);
        if (ins_valid_o || data_valid_o) begin
            $display("An answer is still valid right after the flush");
            n_other_err++;
        end
    endtask

    initial begin : p_watchdog
        wait (n_rows > 0);
        repeat ((2 * n_rows + 20) * (MEM_PIPE_STAGES + 4)) @(posedge clk_i);
        $display("Timeout: the run did not finish, %0d answers still pending",
                 ins_pend_q.size() + data_pend_q.size());
        $display(">>> FAIL");
        $finish;
    end

    initial begin : p_main
        void'($urandom(42));
        rst_n_i      = 1'b0;
        flush_i      = 1'b0;
        ins_valid_i  = 1'b0;
        ins_req_i    = '0;
        ins_ready_i  = 1'b1;
        data_valid_i = 1'b0;
        data_req_i   = '0;
        build_table();
        n_rows = row_req.size();
        repeat (3) @(posedge clk_i);
        rst_n_i <= 1'b1;

        // Handshake state right after reset
        @(negedge clk_i);
        if (ins_valid_o || data_valid_o || !ins_ready_o || !data_ready_o) begin
            $display("Valid or ready outputs are wrong after reset");
            n_other_err++;
        end

        // First pass with ready held and second with random stalls
        for (int pass = 0; pass < 2; pass++) begin
            stall_en <= (pass == 1);
            for (int r = 0; r < n_rows; r++) begin
                if (row_held[r] && (r == 0 || !row_held[r-1])) begin
                    wait_drain();
                end
                issue_row(r);
                if (row_held[r] && (r + 1 == n_rows || !row_held[r+1])) begin
                    raise_flush();
                end
            end
            wait_drain();
        end

        check_count("answer count", n_issued, n_recv);
        $display("Checks %0d, value errors %0d, other errors %0d",
                 n_checks, n_val_err, n_other_err);
        if (n_val_err == 0 && n_other_err == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

//--- verilog.f
+incdir+sim
hdl/mem_emu_pkg.sv
hdl/mem_ans_if.sv
hdl/mem_req_check.sv
hdl/mem_storage.sv
hdl/mem_latency_pipe.sv
hdl/spill_cell_flush.sv
hdl/mem_emu_top.sv
sim/tb_mem_emu.sv
